/* eccPkg.sv */
//////////////////////////////////////////////////
// Shared package for the ECC memory
// Code widths, vector typedefs and the Hsiao
// check matrix column function
//////////////////////////////////////////////////

package eccPkg;

  // Data word and check bit widths of the single code size
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned ProtWidth  = 7;
  localparam int unsigned TotalWidth = DataWidth + ProtWidth;

  // Word addressing of the storage array
  localparam int unsigned AddrWidth = 6;
  localparam int unsigned Depth     = 2 ** AddrWidth;

  // Width of each event counter in the error log
  localparam int unsigned CountWidth = 16;

  // Number of ones in every data column of the matrix
  localparam int unsigned DataColWeight = 3;

  typedef logic [DataWidth-1:0]  dataT;
  typedef logic [ProtWidth-1:0]  protT;
  typedef logic [TotalWidth-1:0] codeT;
  typedef logic [AddrWidth-1:0]  addrT;
  typedef logic [CountWidth-1:0] countT;

  // Bit 0 flags a corrected single error, bit 1 an uncorrectable double error
  typedef logic [1:0] errT;

  // Column of the check matrix for codeword position p
  // Data columns take the weight-three values in ascending order and
  // check columns form an identity block, so every column has odd weight
  function automatic protT hsiaoColumn(input int unsigned p);
    int unsigned seen;
    protT col;
    seen = 0;
    col  = '0;
    if (p >= DataWidth) begin
      // Check bit k sits alone in its own column
      col[p - DataWidth] = 1'b1;
    end else begin
      // Walk all 7-bit values and keep the p-th one of weight three
      for (int v = 0; v < 2 ** ProtWidth; v++) begin
        if ($countones(v) == DataColWeight) begin
          if (seen == p) begin
            col = protT'(v);
          end
          seen++;
        end
      end
    end
    return col;
  endfunction

endpackage

/* eccMemIf.sv */
//////////////////////////////////////////////////
// Request interface between the ECC controller
// and the codeword storage array
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface eccMemIf;

  // Write port, the array captures wrWord on an edge with wrEn high
  logic          wrEn;
  eccPkg::addrT  wrAddr;
  eccPkg::codeT  wrWord;

  // Read port, rdWord is valid in the cycle after rdEn
  logic          rdEn;
  eccPkg::addrT  rdAddr;
  eccPkg::codeT  rdWord;

  // Controller side issues requests and takes the read word
  modport ctrl (
    output wrEn, wrAddr, wrWord, rdEn, rdAddr,
    input  rdWord
  );

  // Storage side serves the requests
  modport mem (
    input  wrEn, wrAddr, wrWord, rdEn, rdAddr,
    output rdWord
  );

endinterface

/* hsiaoEccEnc.sv */
//////////////////////////////////////////////////
// Combinational Hsiao SECDED encoder
//////////////////////////////////////////////////

`timescale 1ns/100ps

module hsiaoEccEnc (
  input  eccPkg::dataT data,
  output eccPkg::codeT code
);

  // One masked column per data bit
  logic [eccPkg::DataWidth-1:0][eccPkg::ProtWidth-1:0] terms;
  eccPkg::protT check;

  for (genvar i = 0; i < eccPkg::DataWidth; i++) begin : genTerm
    // Column is fixed at elaboration
    localparam eccPkg::protT Col = eccPkg::hsiaoColumn(i);

    // A set data bit contributes its column to the check bits
    assign terms[i] = {eccPkg::ProtWidth{data[i]}} & Col;
  end

  // Check bit k is the parity of all data bits whose column has bit k set
  always_comb begin
    check = '0;
    for (int i = 0; i < eccPkg::DataWidth; i++) begin
      check ^= terms[i];
    end
  end

  // Check bits sit above the data in the stored word
  assign code = {check, data};

endmodule

/* hsiaoEccDec.sv */
//////////////////////////////////////////////////
// Combinational Hsiao SECDED decoder
// Syndrome, single-bit correction, error class
//////////////////////////////////////////////////

`timescale 1ns/100ps

module hsiaoEccDec (
  input  eccPkg::codeT code,
  output eccPkg::dataT data,
  output eccPkg::protT syndrome,
  output eccPkg::errT  err
);

  // Column contribution of every codeword bit
  logic [eccPkg::TotalWidth-1:0][eccPkg::ProtWidth-1:0] terms;
  logic oddWeight;

  for (genvar i = 0; i < eccPkg::TotalWidth; i++) begin : genCol
    localparam eccPkg::protT Col = eccPkg::hsiaoColumn(i);

    assign terms[i] = {eccPkg::ProtWidth{code[i]}} & Col;

    // Data bits flip only when the syndrome points exactly at them
    if (i < eccPkg::DataWidth) begin : genFix
      assign data[i] = code[i] ^ (syndrome == Col);
    end
  end

  // Syndrome bit k is the parity over the codeword bits covered by row k
  always_comb begin
    syndrome = '0;
    for (int i = 0; i < eccPkg::TotalWidth; i++) begin
      syndrome ^= terms[i];
    end
  end

  // All columns have odd weight, so one flipped bit gives an odd syndrome
  assign oddWeight = ^syndrome;

  // Two flipped bits cancel to an even but nonzero syndrome
  // No data column matches in that case, so the raw data passes through
  assign err[0] = oddWeight;
  assign err[1] = ~oddWeight & (|syndrome);

endmodule

/* eccMemArray.sv */
//////////////////////////////////////////////////
// Codeword storage array
// One write port and one registered read port
//////////////////////////////////////////////////

`timescale 1ns/100ps

module eccMemArray (
  input logic clk,
  eccMemIf.mem mem
);

  // Codeword storage, contents are undefined until written
  eccPkg::codeT storage [eccPkg::Depth];

  // Write and read share the edge
  // A read of the address being written returns the previous word
  always_ff @(posedge clk) begin
    if (mem.wrEn) begin
      storage[mem.wrAddr] <= mem.wrWord;
    end
    if (mem.rdEn) begin
      mem.rdWord <= storage[mem.rdAddr];
    end
  end

endmodule

/* eccMemCtrl.sv */
//////////////////////////////////////////////////
// ECC memory controller
// Write encode with fault injection, pipelined
// read decode and scrub write-back
//////////////////////////////////////////////////

`timescale 1ns/100ps

module eccMemCtrl (
  input  logic         clk,
  input  logic         arstN,
  input  logic         wrStb,
  input  eccPkg::addrT wrAddr,
  input  eccPkg::dataT wrData,
  input  logic         injEn,
  input  eccPkg::codeT injMask,
  input  logic         rdStb,
  input  eccPkg::addrT rdAddr,
  output logic         rdValid,
  output eccPkg::dataT rdData,
  output logic         errCorrected,
  output logic         errUncorrectable,
  output eccPkg::protT rdSyndrome,
  output eccPkg::addrT rdAddrOut,
  eccMemIf.ctrl        bus
);

  eccPkg::codeT userCode;
  eccPkg::codeT userWord;
  eccPkg::codeT scrubCode;
  eccPkg::dataT decData;
  eccPkg::protT decSyn;
  eccPkg::errT  decErr;
  logic         scrubReq;

  // Second read stage, lines up with the word coming out of the array
  logic         pendValid;
  eccPkg::addrT pendAddr;

  // User write path
  hsiaoEccEnc uEncUser (
    .data (wrData),
    .code (userCode)
  );

  // The injection mask flips stored bits of this write only
  assign userWord = userCode ^ (injMask & {eccPkg::TotalWidth{injEn}});

  // Scrub path re-encodes the corrected word sitting on the outputs
  hsiaoEccEnc uEncScrub (
    .data (rdData),
    .code (scrubCode)
  );

  // Decode of the word the array returned
  hsiaoEccDec uDec (
    .code     (bus.rdWord),
    .data     (decData),
    .syndrome (decSyn),
    .err      (decErr)
  );

  // A corrected read asks for write-back while its result is on the outputs
  assign scrubReq = rdValid & errCorrected;

  // Control state of both ports and the read pipeline
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bus.wrEn         <= 1'b0;
      bus.rdEn         <= 1'b0;
      pendValid        <= 1'b0;
      rdValid          <= 1'b0;
      errCorrected     <= 1'b0;
      errUncorrectable <= 1'b0;
    end else begin
      // User write and scrub share the single write port
      bus.wrEn         <= wrStb | scrubReq;
      // First stage, the array reads on the following edge
      bus.rdEn         <= rdStb;
      pendValid        <= bus.rdEn;
      // Second stage, the decode result lands on the outputs
      rdValid          <= pendValid;
      errCorrected     <= pendValid & decErr[0];
      errUncorrectable <= pendValid & decErr[1];
    end
  end

  // Address and data payload, qualified by the enables above
  always_ff @(posedge clk) begin
    // A user write wins the port and the pending scrub is dropped
    if (wrStb) begin
      bus.wrAddr <= wrAddr;
      bus.wrWord <= userWord;
    end else begin
      bus.wrAddr <= rdAddrOut;
      bus.wrWord <= scrubCode;
    end
    bus.rdAddr <= rdAddr;
    pendAddr   <= bus.rdAddr;
    // Read results for the outputs, the log and the scrub path
    rdData     <= decData;
    rdSyndrome <= decSyn;
    rdAddrOut  <= pendAddr;
  end

endmodule

/* eccErrLog.sv */
//////////////////////////////////////////////////
// Error log with saturating event counters and
// last-error address and syndrome capture
//////////////////////////////////////////////////

`timescale 1ns/100ps

module eccErrLog (
  input  logic          clk,
  input  logic          arstN,
  input  logic          rdValid,
  input  logic          errCorrected,
  input  logic          errUncorrectable,
  input  eccPkg::protT  rdSyndrome,
  input  eccPkg::addrT  rdAddrOut,
  input  logic          clrStb,
  output eccPkg::countT corrCount,
  output eccPkg::countT uncorrCount,
  output eccPkg::addrT  lastErrAddr,
  output eccPkg::protT  lastSyndrome
);

  logic anyErr;

  // Flags only carry meaning together with rdValid
  assign anyErr = rdValid & (errCorrected | errUncorrectable);

  // Events come from the registered read outputs
  // so the log moves one edge after rdValid rises
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      corrCount    <= '0;
      uncorrCount  <= '0;
      lastErrAddr  <= '0;
      lastSyndrome <= '0;
    end else if (clrStb) begin
      // Clear has priority over an event on the same edge
      corrCount    <= '0;
      uncorrCount  <= '0;
      lastErrAddr  <= '0;
      lastSyndrome <= '0;
    end else begin
      // Counters stop at all ones instead of wrapping
      if (rdValid && errCorrected && (corrCount != '1)) begin
        corrCount <= corrCount + 1'b1;
      end
      if (rdValid && errUncorrectable && (uncorrCount != '1)) begin
        uncorrCount <= uncorrCount + 1'b1;
      end
      // Keep the location and syndrome of the most recent fault
      if (anyErr) begin
        lastErrAddr  <= rdAddrOut;
        lastSyndrome <= rdSyndrome;
      end
    end
  end

endmodule

/* eccMemTop.sv */
//////////////////////////////////////////////////
// ECC protected memory top level
// Controller, storage array and error log
//////////////////////////////////////////////////

`timescale 1ns/100ps

module eccMemTop (
  input  logic          clk,
  input  logic          arstN,
  input  logic          wrStb,
  input  eccPkg::addrT  wrAddr,
  input  eccPkg::dataT  wrData,
  input  logic          injEn,
  input  eccPkg::codeT  injMask,
  input  logic          rdStb,
  input  eccPkg::addrT  rdAddr,
  input  logic          clrStb,
  output logic          rdValid,
  output eccPkg::dataT  rdData,
  output logic          errCorrected,
  output logic          errUncorrectable,
  output eccPkg::countT corrCount,
  output eccPkg::countT uncorrCount,
  output eccPkg::addrT  lastErrAddr,
  output eccPkg::protT  lastSyndrome
);

  // Syndrome and address of the read on the outputs, for the log
  eccPkg::protT rdSyndrome;
  eccPkg::addrT rdAddrOut;

  // Request bus between the controller and the array
  eccMemIf memBus ();

  eccMemCtrl uCtrl (
    .clk              (clk),
    .arstN            (arstN),
    .wrStb            (wrStb),
    .wrAddr           (wrAddr),
    .wrData           (wrData),
    .injEn            (injEn),
    .injMask          (injMask),
    .rdStb            (rdStb),
    .rdAddr           (rdAddr),
    .rdValid          (rdValid),
    .rdData           (rdData),
    .errCorrected     (errCorrected),
    .errUncorrectable (errUncorrectable),
    .rdSyndrome       (rdSyndrome),
    .rdAddrOut        (rdAddrOut),
    .bus              (memBus)
  );

  eccMemArray uArray (
    .clk (clk),
    .mem (memBus)
  );

  eccErrLog uLog (
    .clk              (clk),
    .arstN            (arstN),
    .rdValid          (rdValid),
    .errCorrected     (errCorrected),
    .errUncorrectable (errUncorrectable),
    .rdSyndrome       (rdSyndrome),
    .rdAddrOut        (rdAddrOut),
    .clrStb           (clrStb),
    .corrCount        (corrCount),
    .uncorrCount      (uncorrCount),
    .lastErrAddr      (lastErrAddr),
    .lastSyndrome     (lastSyndrome)
  );

endmodule

/* tbEccMem.sv */
//////////////////////////////////////////////////
// Self-checking testbench for the ECC memory
// Own Hsiao code model, stimulus, assertions
// and a watchdog
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tbEccMem;

  localparam int ClkPeriod = 8;
  // Sweep writes and reads plus the directed fault cases
  localparam int NumOps = 2 * eccPkg::Depth + 40;
  localparam int MarginCycles = 100;

  logic          clk;
  logic          arstN;
  logic          wrStb;
  eccPkg::addrT  wrAddr;
  eccPkg::dataT  wrData;
  logic          injEn;
  eccPkg::codeT  injMask;
  logic          rdStb;
  eccPkg::addrT  rdAddr;
  logic          clrStb;
  logic          rdValid;
  eccPkg::dataT  rdData;
  logic          errCorrected;
  logic          errUncorrectable;
  eccPkg::countT corrCount;
  eccPkg::countT uncorrCount;
  eccPkg::addrT  lastErrAddr;
  eccPkg::protT  lastSyndrome;

  integer seed = 32'h2b35_d489;
  int valueErrs = 0;
  int otherErrs = 0;

  // Expected memory contents as clean data plus the fault mask still stored
  eccPkg::dataT memData [eccPkg::Depth];
  eccPkg::codeT memMask [eccPkg::Depth];

  // Expectation of the read strobed in the current cycle
  eccPkg::dataT issD;
  logic         issC;
  logic         issU;
  eccPkg::protT issS;
  eccPkg::addrT issA;

  // Expectation pipeline where stage 2 lines up with rdValid
  logic [2:0]   expV;
  eccPkg::dataT expD [3];
  logic         expC [3];
  logic         expU [3];
  eccPkg::protT expS [3];
  eccPkg::addrT expA [3];

  // Reference error log
  eccPkg::countT refCorr;
  eccPkg::countT refUncorr;
  eccPkg::addrT  refAddr;
  eccPkg::protT  refSyn;

  eccMemTop DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Column p of the check matrix, from the weight-three rule
  function automatic eccPkg::protT columnOf(input int p);
    eccPkg::protT c;
    int found;
    int ones;
    c = '0;
    found = -1;
    if (p >= eccPkg::DataWidth) begin
      c[p - eccPkg::DataWidth] = 1'b1;
    end else begin
      for (int v = 0; v < 128; v++) begin
        ones = 0;
        for (int k = 0; k < eccPkg::ProtWidth; k++) begin
          ones += (v >> k) & 1;
        end
        if (ones == 3) begin
          found++;
          if (found == p) begin
            c = eccPkg::protT'(v);
          end
        end
      end
    end
    return c;
  endfunction

  // A clean codeword has a zero syndrome, so only the fault bits count
  function automatic eccPkg::protT syndromeOf(input eccPkg::codeT mask);
    eccPkg::protT s;
    s = '0;
    for (int p = 0; p < eccPkg::TotalWidth; p++) begin
      if (mask[p]) begin
        s ^= columnOf(p);
      end
    end
    return s;
  endfunction

  function automatic int unsigned randBelow(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                input logic [63:0] gotVal);
    valueErrs++;
    $display("mismatch %s expected %h got %h", name, expVal, gotVal);
  endtask

  // Step to the next falling edge and drop every strobe
  task automatic nextCycle();
    @(negedge clk);
    wrStb   = 1'b0;
    injEn   = 1'b0;
    injMask = '0;
    rdStb   = 1'b0;
    clrStb  = 1'b0;
  endtask

  task automatic putWrite(input eccPkg::addrT a, input eccPkg::dataT d,
                          input eccPkg::codeT mask);
    wrStb      = 1'b1;
    wrAddr     = a;
    wrData     = d;
    injEn      = (mask != '0);
    injMask    = mask;
    memData[a] = d;
    memMask[a] = mask;
  endtask

  // One fault is corrected, two pass the raw data bits through
  task automatic putRead(input eccPkg::addrT a);
    eccPkg::codeT m;
    int w;
    m     = memMask[a];
    w     = $countones(m);
    rdStb  = 1'b1;
    rdAddr = a;
    issA   = a;
    issS   = syndromeOf(m);
    issC   = (w == 1);
    issU   = (w == 2);
    issD   = (w == 2) ? memData[a] ^ m[eccPkg::DataWidth-1:0] : memData[a];
  endtask

  // Single read that returns in the cycle rdValid is high and may race the scrub
  // with a write there
  // A read issued right after it is strobed one cycle after rdValid
  task automatic checkedRead(input eccPkg::addrT a, input logic blockScrub,
                             input eccPkg::addrT wa, input eccPkg::dataT wd);
    logic wasSingle;
    int cnt;
    wasSingle = ($countones(memMask[a]) == 1);
    cnt = 0;
    nextCycle();
    putRead(a);
    nextCycle();
    while (!rdValid && cnt < 8) begin
      nextCycle();
      cnt++;
    end
    if (!rdValid) begin
      otherErrs++;
      $display("Read of address %0d never raised rdValid", a);
    end else if (blockScrub) begin
      putWrite(wa, wd, '0);
    end
    // The write-back repairs the stored word unless the port was taken
    if (wasSingle && !blockScrub) begin
      memMask[a] = '0;
    end
  endtask

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      expV <= '0;
    end else begin
      expV <= {expV[1:0], rdStb};
    end
  end

  always @(posedge clk) begin
    for (int i = 2; i > 0; i--) begin
      expD[i] <= expD[i-1];
      expC[i] <= expC[i-1];
      expU[i] <= expU[i-1];
      expS[i] <= expS[i-1];
      expA[i] <= expA[i-1];
    end
    expD[0] <= issD;
    expC[0] <= issC;
    expU[0] <= issU;
    expS[0] <= issS;
    expA[0] <= issA;
  end

  // Log follows each read result on the outputs and clears on clrStb
  always @(posedge clk or negedge arstN) begin
    if (!arstN || clrStb) begin
      refCorr   <= '0;
      refUncorr <= '0;
      refAddr   <= '0;
      refSyn    <= '0;
    end else if (expV[2] && (expC[2] || expU[2])) begin
      refCorr   <= refCorr + eccPkg::countT'(expC[2]);
      refUncorr <= refUncorr + eccPkg::countT'(expU[2]);
      refAddr   <= expA[2];
      refSyn    <= expS[2];
    end
  end

  latencyChk: assert property (@(posedge clk) disable iff (!arstN) rdValid == expV[2])
    else reportMismatch("rdValid", $sampled(expV[2]), $sampled(rdValid));
  dataChk: assert property (@(posedge clk) disable iff (!arstN) expV[2] |-> rdData == expD[2])
    else reportMismatch("rdData", $sampled(expD[2]), $sampled(rdData));
  corrChk: assert property (@(posedge clk) disable iff (!arstN)
    expV[2] |-> errCorrected == expC[2])
    else reportMismatch("errCorrected", $sampled(expC[2]), $sampled(errCorrected));
  uncorrChk: assert property (@(posedge clk) disable iff (!arstN)
    expV[2] |-> errUncorrectable == expU[2])
    else reportMismatch("errUncorrectable", $sampled(expU[2]), $sampled(errUncorrectable));
  corrCountChk: assert property (@(posedge clk) disable iff (!arstN) corrCount == refCorr)
    else reportMismatch("corrCount", $sampled(refCorr), $sampled(corrCount));
  uncorrCountChk: assert property (@(posedge clk) disable iff (!arstN) uncorrCount == refUncorr)
    else reportMismatch("uncorrCount", $sampled(refUncorr), $sampled(uncorrCount));
  lastAddrChk: assert property (@(posedge clk) disable iff (!arstN) lastErrAddr == refAddr)
    else reportMismatch("lastErrAddr", $sampled(refAddr), $sampled(lastErrAddr));
  lastSynChk: assert property (@(posedge clk) disable iff (!arstN) lastSyndrome == refSyn)
    else reportMismatch("lastSyndrome", $sampled(refSyn), $sampled(lastSyndrome));

  initial begin
    #((NumOps * 10 + MarginCycles) * ClkPeriod);
    otherErrs++;
    $display("Watchdog expired before the test sequence completed");
    $display("Errors: %0d mismatches, %0d other failures", valueErrs, otherErrs);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    eccPkg::addrT a;
    eccPkg::addrT b;
    int bit0;
    int bit1;
    {wrStb, injEn, rdStb, clrStb} = '0;
    {wrAddr, rdAddr, wrData, injMask} = '0;
    {issD, issC, issU, issS, issA} = '0;
    arstN = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    // Clean sweep, then back-to-back reads of every word
    for (int i = 0; i < eccPkg::Depth; i++) begin
      nextCycle();
      putWrite(eccPkg::addrT'(i), eccPkg::dataT'($random(seed)), '0);
    end
    for (int i = 0; i < eccPkg::Depth; i++) begin
      nextCycle();
      putRead(eccPkg::addrT'(i));
    end
    repeat (4) nextCycle();

    // A read beside a write to the same word sees the old contents
    a = eccPkg::addrT'(randBelow(eccPkg::Depth));
    nextCycle();
    putRead(a);
    putWrite(a, eccPkg::dataT'($random(seed)), '0);
    repeat (3) nextCycle();
    checkedRead(a, 1'b0, '0, '0);

    // Single fault in the data field, then in the check field
    bit0 = randBelow(eccPkg::DataWidth);
    bit1 = eccPkg::DataWidth + randBelow(eccPkg::ProtWidth);
    for (int i = 0; i < 2; i++) begin
      a = eccPkg::addrT'(randBelow(eccPkg::Depth));
      nextCycle();
      putWrite(a, eccPkg::dataT'($random(seed)), eccPkg::codeT'(1) << (i == 0 ? bit0 : bit1));
      checkedRead(a, 1'b0, '0, '0);
      checkedRead(a, 1'b0, '0, '0);
    end

    // Two data bits flipped stay flagged on every read
    a    = eccPkg::addrT'(randBelow(eccPkg::Depth));
    bit0 = randBelow(eccPkg::DataWidth);
    bit1 = (bit0 + 1 + randBelow(eccPkg::DataWidth - 1)) % eccPkg::DataWidth;
    nextCycle();
    putWrite(a, eccPkg::dataT'($random(seed)),
             (eccPkg::codeT'(1) << bit0) | (eccPkg::codeT'(1) << bit1));
    checkedRead(a, 1'b0, '0, '0);
    checkedRead(a, 1'b0, '0, '0);

    // User write to another word takes the port from the scrub
    a = eccPkg::addrT'(randBelow(eccPkg::Depth));
    b = eccPkg::addrT'((a + 1 + randBelow(eccPkg::Depth - 1)) % eccPkg::Depth);
    nextCycle();
    putWrite(a, eccPkg::dataT'($random(seed)), eccPkg::codeT'(1) << randBelow(39));
    checkedRead(a, 1'b1, b, eccPkg::dataT'($random(seed)));
    checkedRead(a, 1'b0, '0, '0);
    checkedRead(b, 1'b0, '0, '0);
    checkedRead(a, 1'b0, '0, '0);

    // Clear the log after it has counted events
    nextCycle();
    clrStb = 1'b1;
    repeat (4) nextCycle();

    $display("Errors: %0d mismatches, %0d other failures", valueErrs, otherErrs);
    if (valueErrs == 0 && otherErrs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* eccMemTop.f */
eccPkg.sv
eccMemIf.sv
hsiaoEccEnc.sv
hsiaoEccDec.sv
eccMemArray.sv
eccMemCtrl.sv
eccErrLog.sv
eccMemTop.sv
tbEccMem.sv

/* Makefile */
# Verilator build, run, lint and clean for the ECC memory

VERILATOR   ?= verilator
TOP         ?= tbEccMem
RTL_TOP     ?= eccMemTop
FILELIST    ?= eccMemTop.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_MSG    ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line appears in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
